/* btb.f */
hw/bp_pkg.sv
hw/bp_update_if.sv
hw/btb_ram.sv
hw/btb_advance.sv
hw/btb_local.sv
hw/btb.sv
testbench/btb_props.sv
testbench/tb_btb.sv

/* hw/bp_pkg.sv */
//**********************************************************
// types shared by the BTB blocks, 32-bit PCs, 4-byte insts
// branch codes double as prediction codes (00 = not taken)
//**********************************************************

package bp_pkg;

    // instruction address, bits 1:0 always zero in practice
    typedef logic [31:0] pc_t;

    // branch type as stored in the target cache
    typedef logic [1:0] btype_t;

    // 2-bit saturating direction counter, bit 1 set = taken
    typedef logic [1:0] ctr_t;

    localparam btype_t BT_NONE     = 2'b00; // not a branch
    localparam btype_t BT_UNCOND   = 2'b01; // direct jump
    localparam btype_t BT_COND     = 2'b10; // pc-relative conditional
    localparam btype_t BT_INDIRECT = 2'b11; // register target, always taken

    // counters come out of reset leaning taken
    localparam ctr_t CTR_RESET = 2'b10;

endpackage : bp_pkg

/* hw/bp_update_if.sv */
//**********************************************************
// one resolved branch from execute, no handshake
//**********************************************************

`timescale 1ns/10ps

interface bp_update_if;
    import bp_pkg::*;

    logic   valid;      // one-cycle strobe
    pc_t    pc;         // branch address
    pc_t    tpc;        // resolved target
    logic   taken;      // resolved direction
    btype_t btype;
    logic   dir_fail;   // direction mispredicted
    logic   add_fail;   // target mispredicted

    modport src (output valid, pc, tpc, taken, btype, dir_fail, add_fail);
    modport dst (input  valid, pc, tpc, taken, btype, dir_fail, add_fail);

endinterface : bp_update_if

/* hw/btb.sv */
//**********************************************************
// zero-latency next-PC prediction, updates visible next cycle
// on a miss or not-taken guess pred_pc is the fall-through PC
//**********************************************************

`timescale 1ns/10ps

module btb #(
    parameter int INDEX_WIDTH       = 7,
    parameter int TAG_WIDTH         = 7,
    parameter int LOCAL_INDEX_WIDTH = 6
) (
    input  logic            clk,
    input  logic            rstn,
    input  bp_pkg::pc_t     fetch_pc,
    output bp_pkg::pc_t     pred_pc,
    output bp_pkg::btype_t  pred_taken,
    input  logic            fact_valid,
    input  bp_pkg::pc_t     fact_pc,
    input  bp_pkg::pc_t     fact_tpc,
    input  logic            fact_taken,
    input  bp_pkg::btype_t  fact_btype,
    input  logic            predict_dir_fail,
    input  logic            predict_add_fail
);
    import bp_pkg::*;

    bp_update_if upd_if ();

    logic   hit;
    pc_t    hit_target;
    btype_t hit_btype;
    ctr_t   local_ctr;
    pc_t    fall_pc;
    logic   take;

    // bundle the execute-stage feedback
    assign upd_if.valid    = fact_valid;
    assign upd_if.pc       = fact_pc;
    assign upd_if.tpc      = fact_tpc;
    assign upd_if.taken    = fact_taken;
    assign upd_if.btype    = fact_btype;
    assign upd_if.dir_fail = predict_dir_fail;
    assign upd_if.add_fail = predict_add_fail;

    btb_advance #(
        .INDEX_WIDTH ( INDEX_WIDTH ),
        .TAG_WIDTH   ( TAG_WIDTH   )
    ) u_btb_advance (
        .clk        ( clk        ),
        .rstn       ( rstn       ),
        .fetch_pc   ( fetch_pc   ),
        .upd        ( upd_if     ),
        .hit        ( hit        ),
        .hit_target ( hit_target ),
        .hit_btype  ( hit_btype  )
    );

    btb_local #(
        .LOCAL_INDEX_WIDTH ( LOCAL_INDEX_WIDTH )
    ) u_btb_local (
        .clk       ( clk       ),
        .rstn      ( rstn      ),
        .fetch_pc  ( fetch_pc  ),
        .upd       ( upd_if    ),
        .local_ctr ( local_ctr )
    );

    // second slot of a pair only advances one instruction
    assign fall_pc = fetch_pc[2] ? fetch_pc + 32'd4 : fetch_pc + 32'd8;

    always_comb begin
        take = 1'b0;
        if (hit) begin
            case (hit_btype)
                BT_UNCOND, BT_INDIRECT: take = 1'b1;
                BT_COND:                take = local_ctr[1];
                default:                take = 1'b0;
            endcase
        end
    end

    assign pred_taken = take ? hit_btype : BT_NONE;
    assign pred_pc    = take ? hit_target : fall_pc;

endmodule : btb

/* hw/btb_advance.sv */
//**********************************************************
// direct-mapped target cache, INDEX_WIDTH+TAG_WIDTH <= 29
// allocates only on taken branches that were mispredicted
//**********************************************************

`timescale 1ns/10ps

module btb_advance #(
    parameter int INDEX_WIDTH = 7,
    parameter int TAG_WIDTH   = 7
) (
    input  logic            clk,
    input  logic            rstn,
    input  bp_pkg::pc_t     fetch_pc,
    bp_update_if.dst        upd,
    output logic            hit,
    output bp_pkg::pc_t     hit_target,
    output bp_pkg::btype_t  hit_btype
);
    import bp_pkg::*;

    localparam int ENTRIES = 1 << INDEX_WIDTH;
    localparam int IDX_LO  = 3;                     // pairs of 8 bytes
    localparam int IDX_HI  = INDEX_WIDTH + 2;
    localparam int TAG_LO  = INDEX_WIDTH + 3;
    localparam int TAG_HI  = INDEX_WIDTH + TAG_WIDTH + 2;

    typedef logic [INDEX_WIDTH-1:0] idx_t;
    typedef logic [TAG_WIDTH-1:0]   tag_t;

    logic [ENTRIES-1:0] valid_q;
    tag_t               tag_q   [ENTRIES];
    btype_t             btype_q [ENTRIES];

    idx_t fetch_idx;
    tag_t fetch_tag;
    idx_t upd_idx;
    tag_t upd_tag;
    logic alloc;

    assign fetch_idx = fetch_pc[IDX_HI:IDX_LO];
    assign fetch_tag = fetch_pc[TAG_HI:TAG_LO];
    assign upd_idx   = upd.pc[IDX_HI:IDX_LO];
    assign upd_tag   = upd.pc[TAG_HI:TAG_LO];

    // only taken branches get an entry, and only when we got them wrong
    assign alloc = upd.valid && upd.taken && (upd.dir_fail || upd.add_fail);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (alloc) begin
            valid_q[upd_idx] <= 1'b1;   // overwrite, no invalidation path
        end
    end

    // tag and type are masked by valid_q until first written
    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_q[upd_idx]   <= upd_tag;
            btype_q[upd_idx] <= upd.btype;
        end
    end

    btb_ram #(
        .DATA_WIDTH ( $bits(pc_t) ),
        .ADDR_WIDTH ( INDEX_WIDTH )
    ) u_btb_ram (
        .clk        ( clk        ),
        .write_addr ( upd_idx    ),
        .write_data ( upd.tpc    ),
        .write_en   ( alloc      ),
        .read_addr  ( fetch_idx  ),
        .read_data  ( hit_target )
    );

    // lookup sees old contents when update hits the same entry
    assign hit       = valid_q[fetch_idx] && (tag_q[fetch_idx] == fetch_tag);
    assign hit_btype = btype_q[fetch_idx];

endmodule : btb_advance

/* hw/btb_local.sv */
//**********************************************************
// untagged 2-bit direction counters, trained on every update
//**********************************************************

`timescale 1ns/10ps

module btb_local #(
    parameter int LOCAL_INDEX_WIDTH = 6
) (
    input  logic         clk,
    input  logic         rstn,
    input  bp_pkg::pc_t  fetch_pc,
    bp_update_if.dst     upd,
    output bp_pkg::ctr_t local_ctr
);
    import bp_pkg::*;

    localparam int ENTRIES = 1 << LOCAL_INDEX_WIDTH;

    typedef logic [LOCAL_INDEX_WIDTH-1:0] lidx_t;

    ctr_t  ctr_q [ENTRIES];
    lidx_t fetch_idx;
    lidx_t upd_idx;
    ctr_t  upd_ctr;

    assign fetch_idx = fetch_pc[LOCAL_INDEX_WIDTH+2:3];
    assign upd_idx   = upd.pc[LOCAL_INDEX_WIDTH+2:3];
    assign upd_ctr   = ctr_q[upd_idx];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_q[i] <= CTR_RESET;      // weak taken
            end
        end else if (upd.valid) begin
            if (upd.taken && !(&upd_ctr)) begin
                ctr_q[upd_idx] <= upd_ctr + 2'd1;
            end else if (!upd.taken && (|upd_ctr)) begin
                ctr_q[upd_idx] <= upd_ctr - 2'd1;
            end
        end
    end

    assign local_ctr = ctr_q[fetch_idx];   // raw counter, top reads bit 1

endmodule : btb_local

/* hw/btb_ram.sv */
//**********************************************************
// target store, contents undefined until written
//**********************************************************

`timescale 1ns/10ps

module btb_ram #(
    parameter int DATA_WIDTH = $bits(bp_pkg::pc_t),
    parameter int ADDR_WIDTH = 7
) (
    input  logic                  clk,
    input  logic [ADDR_WIDTH-1:0] write_addr,
    input  bp_pkg::pc_t           write_data,
    input  logic                  write_en,
    input  logic [ADDR_WIDTH-1:0] read_addr,
    output bp_pkg::pc_t           read_data
);
    import bp_pkg::*;

    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
    end

    // async read, a same-cycle write is not forwarded
    assign read_data = mem[read_addr];

endmodule : btb_ram

/* testbench/btb_props.sv */
//**********************************************************
// bound to btb and checks only while rstn is high
//**********************************************************

`timescale 1ns/10ps

module btb_props (
    input logic           clk,
    input logic           rstn,
    input bp_pkg::pc_t    fetch_pc,
    input bp_pkg::pc_t    pred_pc,
    input bp_pkg::btype_t pred_taken
);
    import bp_pkg::*;

    pc_t fall_pc;
    int  failures = 0;   // read by the testbench at the end

    assign fall_pc = fetch_pc[2] ? fetch_pc + 32'd4 : fetch_pc + 32'd8;  // pair rule

    not_taken_falls_through: assert property (@(posedge clk) disable iff (!rstn)
        (pred_taken == BT_NONE) |-> (pred_pc == fall_pc))
        else begin
            failures++;
            $error("not-taken prediction without fall-through pred_pc");
        end

    code_known: assert property (@(posedge clk) disable iff (!rstn) !$isunknown(pred_taken))
        else begin
            failures++;
            $error("pred_taken unknown");
        end

    target_known: assert property (@(posedge clk) disable iff (!rstn) !$isunknown(pred_pc))
        else begin
            failures++;
            $error("pred_pc unknown");
        end

endmodule : btb_props

/* testbench/tb_btb.sv */
//**********************************************************
// random fetch and update traffic checked against a model
// DUT runs with default parameters and PCs from a small pool
//**********************************************************

`timescale 1ns/10ps

module tb_btb;
    import bp_pkg::*;

    localparam int INDEX_WIDTH       = 7;
    localparam int TAG_WIDTH         = 7;
    localparam int LOCAL_INDEX_WIDTH = 6;
    localparam int ENTRIES           = 1 << INDEX_WIDTH;
    localparam int LOCAL_ENTRIES     = 1 << LOCAL_INDEX_WIDTH;
    localparam int RANDOM_CYCLES     = 3000;

    logic   clk;
    logic   rstn;
    pc_t    fetch_pc;
    pc_t    pred_pc;
    btype_t pred_taken;
    logic   fact_valid;
    pc_t    fact_pc;
    pc_t    fact_tpc;
    logic   fact_taken;
    btype_t fact_btype;
    logic   predict_dir_fail;
    logic   predict_add_fail;

    int     errors;
    integer seed;

    // reference model of the cache and the counters
    logic                 m_valid  [ENTRIES];
    logic [TAG_WIDTH-1:0] m_tag    [ENTRIES];
    btype_t               m_btype  [ENTRIES];
    pc_t                  m_target [ENTRIES];
    ctr_t                 m_ctr    [LOCAL_ENTRIES];

    btb u_dut (
        .clk              ( clk              ),
        .rstn             ( rstn             ),
        .fetch_pc         ( fetch_pc         ),
        .pred_pc          ( pred_pc          ),
        .pred_taken       ( pred_taken       ),
        .fact_valid       ( fact_valid       ),
        .fact_pc          ( fact_pc          ),
        .fact_tpc         ( fact_tpc         ),
        .fact_taken       ( fact_taken       ),
        .fact_btype       ( fact_btype       ),
        .predict_dir_fail ( predict_dir_fail ),
        .predict_add_fail ( predict_add_fail )
    );

    bind btb btb_props u_props (
        .clk        ( clk        ),
        .rstn       ( rstn       ),
        .fetch_pc   ( fetch_pc   ),
        .pred_pc    ( pred_pc    ),
        .pred_taken ( pred_taken )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_pc(input string name, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: pred_pc expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_btype(input string name, input btype_t exp, input btype_t act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: pred_taken expected %b, actual %b", name, exp, act);
        end
    endtask

    function automatic pc_t pool_pc(input int tag, input int idx, input int slot);
        return 32'h0040_0000 | (pc_t'(tag) << (INDEX_WIDTH + 3)) | (pc_t'(idx) << 3)
             | (pc_t'(slot) << 2);
    endfunction

    function automatic pc_t rand_pc();
        int tag;
        int idx;
        int slot;
        tag  = $unsigned($random(seed)) % 4;
        idx  = $unsigned($random(seed)) % 8;   // 8 entries give lots of aliasing
        slot = $unsigned($random(seed)) % 2;
        return pool_pc(tag, idx, slot);
    endfunction

    task automatic model_predict(input pc_t pc, output btype_t code, output pc_t npc);
        int   idx;
        logic hit;
        logic take;
        idx  = int'(pc[INDEX_WIDTH+2:3]);
        hit  = m_valid[idx] && (m_tag[idx] == pc[INDEX_WIDTH+TAG_WIDTH+2:INDEX_WIDTH+3]);
        take = hit && ((m_btype[idx] == BT_UNCOND) || (m_btype[idx] == BT_INDIRECT)
               || ((m_btype[idx] == BT_COND) && m_ctr[int'(pc[LOCAL_INDEX_WIDTH+2:3])][1]));
        code = take ? m_btype[idx] : BT_NONE;
        npc  = take ? m_target[idx] : (pc[2] ? pc + 32'd4 : pc + 32'd8);
    endtask

    // consumes whatever update the DUT samples at this edge
    task automatic model_update();
        int idx;
        int lidx;
        idx  = int'(fact_pc[INDEX_WIDTH+2:3]);
        lidx = int'(fact_pc[LOCAL_INDEX_WIDTH+2:3]);
        if (fact_valid) begin
            if (fact_taken && (predict_dir_fail || predict_add_fail)) begin
                m_valid[idx]  = 1'b1;
                m_tag[idx]    = fact_pc[INDEX_WIDTH+TAG_WIDTH+2:INDEX_WIDTH+3];
                m_btype[idx]  = fact_btype;
                m_target[idx] = fact_tpc;
            end
            if (fact_taken && (m_ctr[lidx] != 2'b11)) begin
                m_ctr[lidx] = m_ctr[lidx] + 2'd1;
            end else if (!fact_taken && (m_ctr[lidx] != 2'b00)) begin
                m_ctr[lidx] = m_ctr[lidx] - 2'd1;
            end
        end
    endtask

    // one fetch and optional update per cycle, compared at the falling edge
    task automatic step(input string name, input pc_t fpc, input logic v, input pc_t upc,
                        input pc_t tpc, input logic tk, input btype_t bt);
        btype_t ucode;
        pc_t    unpc;
        btype_t ecode;
        pc_t    enpc;
        @(posedge clk);
        model_update();
        model_predict(upc, ucode, unpc);   // fail strobes from the guess before training
        fetch_pc         <= fpc;
        fact_valid       <= v;
        fact_pc          <= upc;
        fact_tpc         <= tpc;
        fact_taken       <= tk;
        fact_btype       <= bt;
        predict_dir_fail <= v && ((ucode != BT_NONE) != tk);
        predict_add_fail <= v && tk && (ucode != BT_NONE) && (unpc != tpc);
        @(negedge clk);
        model_predict(fpc, ecode, enpc);
        check_btype(name, ecode, pred_taken);
        check_pc(name, enpc, pred_pc);
    endtask

    task automatic fetch_only(input string name, input pc_t fpc);
        step(name, fpc, 1'b0, fpc, 32'h0, 1'b0, BT_NONE);
    endtask

    initial begin
        int     n;
        pc_t    a;
        pc_t    b;
        pc_t    c;
        pc_t    d;
        pc_t    f;
        pc_t    u;
        btype_t bt;
        logic   tk;
        errors           = 0;
        seed             = 32'h1929;
        rstn             = 1'b0;
        fetch_pc         = '0;
        fact_valid       = 1'b0;
        fact_pc          = '0;
        fact_tpc         = '0;
        fact_taken       = 1'b0;
        fact_btype       = BT_NONE;
        predict_dir_fail = 1'b0;
        predict_add_fail = 1'b0;
        for (int i = 0; i < ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        for (int i = 0; i < LOCAL_ENTRIES; i++) begin
            m_ctr[i] = CTR_RESET;
        end

        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        n = 0;
        while ((rstn !== 1'b1 || $isunknown(pred_taken) || $isunknown(pred_pc)) && n < 16) begin
            @(posedge clk);
            n++;
        end
        if (rstn !== 1'b1 || $isunknown(pred_taken) || $isunknown(pred_pc)) begin
            $display("timeout: prediction outputs still unknown after reset release");
            $display("Test FAILED");
            $finish;
        end

        // empty cache gives only fall-through
        fetch_only("reset_fallthrough", pool_pc(1, 3, 0));
        fetch_only("reset_fallthrough", pool_pc(1, 3, 1));
        repeat (40) fetch_only("reset_fallthrough", rand_pc());

        // unconditional and indirect allocation
        a = pool_pc(1, 21, 0);
        step("uncond_alloc", a, 1'b1, a, 32'h0010_2000, 1'b1, BT_UNCOND);
        fetch_only("uncond_hit", a);
        check_btype("uncond_hit_type", BT_UNCOND, pred_taken);
        check_pc("uncond_hit_target", 32'h0010_2000, pred_pc);
        b = pool_pc(2, 22, 1);
        step("indirect_alloc", b, 1'b1, b, 32'h0010_3000, 1'b1, BT_INDIRECT);
        fetch_only("indirect_hit", b);
        check_btype("indirect_hit_type", BT_INDIRECT, pred_taken);
        check_pc("indirect_hit_target", 32'h0010_3000, pred_pc);

        // conditional follows its counter which saturates at both ends
        c = pool_pc(0, 25, 0);
        step("cond_alloc", c, 1'b1, c, 32'h0010_4000, 1'b1, BT_COND);
        fetch_only("cond_taken", c);
        repeat (5) step("cond_not_taken", c, 1'b1, c, 32'h0010_4000, 1'b0, BT_COND);
        fetch_only("cond_fallthrough", c);
        check_btype("cond_fallthrough_type", BT_NONE, pred_taken);
        check_pc("cond_fallthrough_pc", c + 32'd8, pred_pc);
        repeat (5) step("cond_taken_again", c, 1'b1, c, 32'h0010_4000, 1'b1, BT_COND);
        fetch_only("cond_restored", c);
        check_pc("cond_restored_target", 32'h0010_4000, pred_pc);

        // same index with another tag
        d = pool_pc(3, 25, 0);
        fetch_only("alias_miss", d);
        check_btype("alias_miss_type", BT_NONE, pred_taken);
        step("alias_alloc", d, 1'b1, d, 32'h0010_5000, 1'b1, BT_UNCOND);
        fetch_only("alias_hit", d);
        fetch_only("evicted_miss", c);
        check_btype("evicted_miss_type", BT_NONE, pred_taken);

        // long random mix where a quarter of updates hit the fetched PC
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            f = rand_pc();
            u = (($unsigned($random(seed)) % 4) == 0) ? f : rand_pc();
            case ($unsigned($random(seed)) % 3)
                0:       bt = BT_UNCOND;
                1:       bt = BT_COND;
                default: bt = BT_INDIRECT;
            endcase
            tk = (bt == BT_COND) ? $random(seed) & 1 : 1'b1;
            step("random_mix", f, $random(seed) & 1, u,
                 32'h0080_0000 + (pc_t'($unsigned($random(seed)) % 4) << 2), tk, bt);
        end
        fetch_only("drain", rand_pc());

        $display("checks done, errors: %0d, assertion failures: %0d",
                 errors, u_dut.u_props.failures);
        if (errors == 0 && u_dut.u_props.failures == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : tb_btb
